//--- l2_geom_pkg.sv
`default_nettype none

package l2_geom_pkg;

    // one memory line, also the unit of a refill beat
    typedef logic [127:0] line_t;

    // byte address as seen by the data cache
    typedef logic [31:0] addr_t;

    // refill group address, byte address bits 31 to 6
    typedef logic [25:0] ic_addr_t;

    // beat number inside a four-line refill
    typedef logic [1:0] seq_t;

    typedef struct packed {
        line_t line;  // line data of this beat
        seq_t  seq;   // 0..3, lowest line first
    } ic_beat_t;

    // 16 byte lines, 64 byte refill groups
    localparam int LINE_BYTES = 16;
    localparam int GROUP_LINES = 4;

endpackage

`default_nettype wire

//--- l2_dc_pkg.sv
`default_nettype none

package l2_dc_pkg;

    import l2_geom_pkg::*;

    // data cache commands, same encoding as the core's memory op field
    typedef enum logic [4:0] {
        CMD_LOAD    = 5'd0,
        CMD_STORE   = 5'd1,
        CMD_AMOSWAP = 5'd4,
        CMD_LR      = 5'd6,
        CMD_SC      = 5'd7,
        CMD_AMOADD  = 5'd8,
        CMD_AMOXOR  = 5'd9,
        CMD_AMOOR   = 5'd10,
        CMD_AMOAND  = 5'd11,
        CMD_AMOMIN  = 5'd12,
        CMD_AMOMAX  = 5'd13,
        CMD_AMOMINU = 5'd14,
        CMD_AMOMAXU = 5'd15
    } cmd_e;

    // access size, the U variants zero extend on loads
    typedef enum logic [3:0] {
        SZ_B, SZ_H, SZ_W, SZ_D,
        SZ_BU, SZ_HU, SZ_WU, SZ_DU,
        SZ_LINE
    } size_e;

    typedef logic [7:0] tag_t;

    typedef struct packed {
        addr_t addr;
        cmd_e  cmd;
        size_e size;
        tag_t  tag;
        line_t wdata;  // store data sits in the low bits
    } dc_req_t;

    typedef struct packed {
        tag_t  tag;
        line_t data;
    } dc_resp_t;

endpackage

`default_nettype wire

//--- l2_line_store.sv
`timescale 1ns/1ps
`default_nettype none

// line array: refill reads on port a, data channel reads on port b and writes
module l2_line_store import l2_geom_pkg::*; #(
    parameter int MEM_LINES = 16
) (
    input  logic                         clk_i,

    input  logic [$clog2(MEM_LINES)-1:0] ra_idx_i,
    output line_t                        ra_line_o,

    input  logic [$clog2(MEM_LINES)-1:0] rb_idx_i,
    output line_t                        rb_line_o,

    input  logic                         we_i,
    input  logic [$clog2(MEM_LINES)-1:0] w_idx_i,
    input  line_t                        w_line_i
);

    localparam int IDX_W = $clog2(MEM_LINES);

    line_t mem_q [MEM_LINES];

    logic [IDX_W-1:0] ra_idx;
    logic [IDX_W-1:0] rb_idx;

    assign ra_idx = ra_idx_i;
    assign rb_idx = rb_idx_i;

    // asynchronous reads
    assign ra_line_o = mem_q[ra_idx];
    assign rb_line_o = mem_q[rb_idx];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[w_idx_i] <= w_line_i;  // visible to both reads next cycle
        end
    end

endmodule

`default_nettype wire

//--- l2_amo_alu.sv
`timescale 1ns/1ps
`default_nettype none

// value written back by a store, sc or atomic
module l2_amo_alu import l2_dc_pkg::*; (
    input  cmd_e        cmd_i,
    input  size_e       size_i,
    input  logic [63:0] mem_val_i,
    input  logic [63:0] core_val_i,
    output logic [63:0] wr_val_o
);

    logic [63:0] mem_op;
    logic [63:0] core_op;
    logic        is_word;

    assign is_word = (size_i == SZ_W);

    // 32-bit amos compare and add as signed 64-bit values
    assign mem_op  = is_word ? {{32{mem_val_i[31]}}, mem_val_i[31:0]} : mem_val_i;
    assign core_op = is_word ? {{32{core_val_i[31]}}, core_val_i[31:0]} : core_val_i;

    always_comb begin
        case (cmd_i)
            CMD_AMOADD:  wr_val_o = mem_op + core_op;
            CMD_AMOXOR:  wr_val_o = mem_op ^ core_op;
            CMD_AMOOR:   wr_val_o = mem_op | core_op;
            CMD_AMOAND:  wr_val_o = mem_op & core_op;
            CMD_AMOMIN: begin
                wr_val_o = ($signed(mem_op) < $signed(core_op)) ? mem_op : core_op;
            end
            CMD_AMOMAX: begin
                wr_val_o = ($signed(mem_op) > $signed(core_op)) ? mem_op : core_op;
            end
            CMD_AMOMINU: begin
                wr_val_o = (mem_op < core_op) ? mem_op : core_op;
            end
            CMD_AMOMAXU: begin
                wr_val_o = (mem_op > core_op) ? mem_op : core_op;
            end
            default: wr_val_o = core_op;  // store, sc, amoswap
        endcase
    end

endmodule

`default_nettype wire

//--- l2_icache_port.sv
`timescale 1ns/1ps
`default_nettype none

module l2_icache_port import l2_geom_pkg::*; #(
    parameter int MEM_LINES  = 16,
    parameter int INST_DELAY = 6
) (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  ic_addr_t                     ic_addr_i,
    input  logic                         ic_valid_i,
    output logic                         ic_ready_o,
    output ic_beat_t                     ic_beat_o,
    output logic                         ic_valid_o,
    output logic [$clog2(MEM_LINES)-1:0] rd_idx_o,
    input  line_t                        rd_line_i
);

    localparam int IDX_W = $clog2(MEM_LINES);
    localparam int CNT_W = $clog2(INST_DELAY + 1);

    typedef enum logic [1:0] {RF_IDLE, RF_WAIT, RF_BURST} rf_state_e;

    rf_state_e        state_q;
    logic [CNT_W-1:0] cnt_q;   // cycles left before the burst
    ic_addr_t         grp_q;
    seq_t             seq_q;
    logic [27:0]      line_num;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= RF_IDLE;
            cnt_q   <= '0;
            seq_q   <= '0;
        end else begin
            case (state_q)
                RF_IDLE: begin
                    if (ic_valid_i) begin
                        seq_q <= '0;
                        cnt_q <= CNT_W'(INST_DELAY - 1);
                        if (INST_DELAY == 1) begin
                            state_q <= RF_BURST;  // first beat right away
                        end else begin
                            state_q <= RF_WAIT;
                        end
                    end
                end
                RF_WAIT: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == CNT_W'(1)) begin
                        state_q <= RF_BURST;
                    end
                end
                RF_BURST: begin
                    seq_q <= seq_q + 1'b1;  // wraps back to 0 after beat 3
                    if (seq_q == 2'd3) begin
                        state_q <= RF_IDLE;
                    end
                end
                default: state_q <= RF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (ic_ready_o && ic_valid_i) begin
            grp_q <= ic_addr_i;
        end
    end

    // group*4 + beat, wrapped to the array size
    assign line_num = {grp_q, seq_q};
    assign rd_idx_o = line_num[IDX_W-1:0];

    assign ic_ready_o = (state_q == RF_IDLE);
    assign ic_valid_o = (state_q == RF_BURST);
    assign ic_beat_o  = '{line: rd_line_i, seq: seq_q};

endmodule

`default_nettype wire

//--- l2_dcache_port.sv
`timescale 1ns/1ps
`default_nettype none

module l2_dcache_port import l2_geom_pkg::*, l2_dc_pkg::*; #(
    parameter int MEM_LINES  = 16,
    parameter int DATA_DELAY = 3
) (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  dc_req_t                      dc_req_i,
    input  logic                         dc_valid_i,
    output logic                         dc_ready_o,
    output dc_resp_t                     dc_resp_o,
    output logic                         dc_valid_o,
    output logic [$clog2(MEM_LINES)-1:0] rd_idx_o,
    input  line_t                        rd_line_i,
    output logic                         we_o,
    output logic [$clog2(MEM_LINES)-1:0] w_idx_o,
    output line_t                        w_line_o
);

    localparam int IDX_W = $clog2(MEM_LINES);
    localparam int CNT_W = $clog2(DATA_DELAY + 1);

    typedef enum logic [1:0] {DC_IDLE, DC_WRITE, DC_WAIT} dc_state_e;

    dc_state_e        state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             resv_q;       // lr reservation held
    addr_t            resv_addr_q;
    dc_req_t          req_q;
    line_t            line_q;       // old line, base for the merge
    line_t            data_q;       // formatted response
    logic             accept;
    logic             sc_ok;
    logic             do_write;
    logic [63:0]      old_val;
    logic [63:0]      alu_val;
    line_t            merged;

    // addressed field, zero extended to 64 bits
    function automatic logic [63:0] field64(line_t line, logic [3:0] off, size_e size);
        case (size)
            SZ_B, SZ_BU: field64 = {56'b0, line[{off, 3'b000} +: 8]};
            SZ_H, SZ_HU: field64 = {48'b0, line[{off[3:1], 4'b0000} +: 16]};
            SZ_W, SZ_WU: field64 = {32'b0, line[{off[3:2], 5'b00000} +: 32]};
            default:     field64 = line[{off[3], 6'b000000} +: 64];
        endcase
    endfunction

    function automatic line_t fmt_load(line_t line, logic [3:0] off, size_e size);
        logic [63:0] f;
        f = field64(line, off, size);
        case (size)
            SZ_B:    fmt_load = {{120{f[7]}}, f[7:0]};
            SZ_H:    fmt_load = {{112{f[15]}}, f[15:0]};
            SZ_W:    fmt_load = {{96{f[31]}}, f[31:0]};
            SZ_D:    fmt_load = {{64{f[63]}}, f};
            SZ_LINE: fmt_load = line;
            default: fmt_load = {64'b0, f};  // unsigned sizes
        endcase
    endfunction

    assign accept   = dc_valid_i && (state_q == DC_IDLE);
    assign sc_ok    = resv_q && (resv_addr_q == dc_req_i.addr);
    assign rd_idx_o = dc_req_i.addr[4 +: IDX_W];

    always_comb begin
        case (dc_req_i.cmd)
            CMD_LOAD, CMD_LR: do_write = 1'b0;
            CMD_SC:           do_write = sc_ok;
            default:          do_write = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= DC_IDLE;
            cnt_q   <= '0;
            resv_q  <= 1'b0;
        end else begin
            case (state_q)
                DC_IDLE: begin
                    if (accept) begin
                        cnt_q <= CNT_W'(DATA_DELAY - 1);
                        if (do_write) begin
                            state_q <= DC_WRITE;
                        end else begin
                            state_q <= DC_WAIT;
                        end
                        if (dc_req_i.cmd == CMD_LR) begin
                            resv_q <= 1'b1;
                        end else if (dc_req_i.cmd == CMD_SC) begin
                            resv_q <= 1'b0;  // cleared whether it passed or not
                        end
                    end
                end
                DC_WRITE: begin
                    cnt_q   <= cnt_q - 1'b1;
                    state_q <= DC_WAIT;
                end
                DC_WAIT: begin
                    if (cnt_q == '0) begin
                        state_q <= DC_IDLE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: state_q <= DC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q  <= dc_req_i;
            line_q <= rd_line_i;
            if (dc_req_i.cmd == CMD_SC) begin
                data_q <= {127'b0, ~sc_ok};  // 0 means success
            end else begin
                data_q <= fmt_load(rd_line_i, dc_req_i.addr[3:0], dc_req_i.size);
            end
            if (dc_req_i.cmd == CMD_LR) begin
                resv_addr_q <= dc_req_i.addr;
            end
        end
    end

    assign old_val = field64(line_q, req_q.addr[3:0], req_q.size);

    l2_amo_alu u_amo_alu (
        .cmd_i      (req_q.cmd),
        .size_i     (req_q.size),
        .mem_val_i  (old_val),
        .core_val_i (req_q.wdata[63:0]),
        .wr_val_o   (alu_val)
    );

    // put the new field back into the old line
    always_comb begin
        merged = line_q;
        case (req_q.size)
            SZ_B, SZ_BU: merged[{req_q.addr[3:0], 3'b000} +: 8]      = alu_val[7:0];
            SZ_H, SZ_HU: merged[{req_q.addr[3:1], 4'b0000} +: 16]    = alu_val[15:0];
            SZ_W, SZ_WU: merged[{req_q.addr[3:2], 5'b00000} +: 32]   = alu_val[31:0];
            SZ_D, SZ_DU: merged[{req_q.addr[3], 6'b000000} +: 64]    = alu_val;
            default:     merged = req_q.wdata;  // whole line
        endcase
    end

    assign we_o     = (state_q == DC_WRITE);
    assign w_idx_o  = req_q.addr[4 +: IDX_W];
    assign w_line_o = merged;

    assign dc_ready_o = (state_q == DC_IDLE);
    assign dc_valid_o = (state_q == DC_WAIT) && (cnt_q == '0);
    assign dc_resp_o  = '{tag: req_q.tag, data: data_q};

endmodule

`default_nettype wire

//--- l2_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module l2_mem_top import l2_geom_pkg::*, l2_dc_pkg::*; #(
    parameter int MEM_LINES  = 256,
    parameter int INST_DELAY = 20,
    parameter int DATA_DELAY = 2
) (
    input  logic     clk_i,
    input  logic     rstn_i,

    // instruction refill channel
    input  ic_addr_t ic_addr_i,
    input  logic     ic_valid_i,
    output logic     ic_ready_o,
    output ic_beat_t ic_beat_o,
    output logic     ic_valid_o,

    // data channel
    input  dc_req_t  dc_req_i,
    input  logic     dc_valid_i,
    output logic     dc_ready_o,
    output dc_resp_t dc_resp_o,
    output logic     dc_valid_o
);

    localparam int IDX_W = $clog2(MEM_LINES);

    logic [IDX_W-1:0] ra_idx;
    logic [IDX_W-1:0] rb_idx;
    logic [IDX_W-1:0] w_idx;
    line_t            ra_line;
    line_t            rb_line;
    line_t            w_line;
    logic             we;

    l2_line_store #(.MEM_LINES(MEM_LINES)) u_line_store (
        .clk_i     (clk_i),
        .ra_idx_i  (ra_idx),
        .ra_line_o (ra_line),
        .rb_idx_i  (rb_idx),
        .rb_line_o (rb_line),
        .we_i      (we),
        .w_idx_i   (w_idx),
        .w_line_i  (w_line)
    );

    l2_icache_port #(
        .MEM_LINES  (MEM_LINES),
        .INST_DELAY (INST_DELAY)
    ) u_icache_port (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .ic_addr_i  (ic_addr_i),
        .ic_valid_i (ic_valid_i),
        .ic_ready_o (ic_ready_o),
        .ic_beat_o  (ic_beat_o),
        .ic_valid_o (ic_valid_o),
        .rd_idx_o   (ra_idx),
        .rd_line_i  (ra_line)
    );

    l2_dcache_port #(
        .MEM_LINES  (MEM_LINES),
        .DATA_DELAY (DATA_DELAY)
    ) u_dcache_port (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .dc_req_i   (dc_req_i),
        .dc_valid_i (dc_valid_i),
        .dc_ready_o (dc_ready_o),
        .dc_resp_o  (dc_resp_o),
        .dc_valid_o (dc_valid_o),
        .rd_idx_o   (rb_idx),
        .rd_line_i  (rb_line),
        .we_o       (we),
        .w_idx_o    (w_idx),
        .w_line_o   (w_line)
    );

endmodule

`default_nettype wire

//--- l2_mem_assert.sv
`timescale 1ns/1ps
`default_nettype none

module l2_mem_assert import l2_geom_pkg::*; #(
    parameter int DATA_DELAY = 3
) (
    input logic     clk_i,
    input logic     rstn_i,
    input logic     dc_valid_i,
    input logic     dc_ready_i,
    input logic     dc_rvalid_i,  // response valid
    input logic     ic_bvalid_i,  // refill beat valid
    input ic_beat_t ic_beat_i
);

    int fail_cnt = 0;  // failed assertions so far

    a_dc_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(dc_rvalid_i && dc_ready_i))
        else begin
            fail_cnt++;
            $error("dc_valid_o and dc_ready_o high together");
        end

    // bursts start at beat 0 and count up without gaps
    a_beat_first: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(ic_bvalid_i) |-> ic_beat_i.seq == 2'd0)
        else begin
            fail_cnt++;
            $error("refill burst does not start at beat 0");
        end

    a_beat_next: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ic_bvalid_i && ic_beat_i.seq != 2'd3 |=>
            ic_bvalid_i && ic_beat_i.seq == $past(ic_beat_i.seq) + 2'd1)
        else begin
            fail_cnt++;
            $error("refill beats out of order or not back to back");
        end

    a_dc_delay: assert property (@(posedge clk_i) disable iff (!rstn_i)
        dc_valid_i && dc_ready_i |=> !dc_rvalid_i [*(DATA_DELAY-1)] ##1 dc_rvalid_i)
        else begin
            fail_cnt++;
            $error("data response not exactly DATA_DELAY cycles after acceptance");
        end

endmodule

bind l2_mem_top l2_mem_assert #(.DATA_DELAY(DATA_DELAY)) u_mem_assert (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .dc_valid_i  (dc_valid_i),
    .dc_ready_i  (dc_ready_o),
    .dc_rvalid_i (dc_valid_o),
    .ic_bvalid_i (ic_valid_o),
    .ic_beat_i   (ic_beat_o)
);

`default_nettype wire

//--- tb_l2_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l2_mem import l2_geom_pkg::*, l2_dc_pkg::*; ();

    localparam int MEM_LINES  = 16;
    localparam int INST_DELAY = 6;
    localparam int DATA_DELAY = 3;
    // roughly 2300 cycles of traffic over the five tests, plus headroom
    localparam int TIMEOUT_CYCLES = 4000;

    logic     clk_i;
    logic     rstn_i;
    ic_addr_t ic_addr_i;
    logic     ic_valid_i;
    logic     ic_ready_o;
    ic_beat_t ic_beat_o;
    logic     ic_valid_o;
    dc_req_t  dc_req_i;
    logic     dc_valid_i;
    logic     dc_ready_o;
    dc_resp_t dc_resp_o;
    logic     dc_valid_o;

    line_t       ref_mem [MEM_LINES];  // reference copy of the line array
    logic        resv;
    addr_t       resv_addr;
    logic [31:0] rng_q;
    int          cycles = 0;

    // stores and amos, sc is driven on its own
    cmd_e wr_cmds [10] = '{CMD_STORE, CMD_AMOSWAP, CMD_AMOADD, CMD_AMOXOR, CMD_AMOOR,
                           CMD_AMOAND, CMD_AMOMIN, CMD_AMOMAX, CMD_AMOMINU, CMD_AMOMAXU};

    l2_mem_top #(
        .MEM_LINES  (MEM_LINES),
        .INST_DELAY (INST_DELAY),
        .DATA_DELAY (DATA_DELAY)
    ) DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a handshake never completed", cycles);
            $display("Done: errors found");
            $fatal(1, "simulation timeout");
        end else if (DUT.u_mem_assert.fail_cnt != 0) begin
            fail_stop("a bound protocol assertion failed");
        end
    end

    function automatic logic [31:0] xorshift();
        rng_q = rng_q ^ (rng_q << 13);
        rng_q = rng_q ^ (rng_q >> 17);
        rng_q = rng_q ^ (rng_q << 5);
        return rng_q;
    endfunction

    function automatic int size_bytes(size_e size);
        case (size)
            SZ_B, SZ_BU: return 1;
            SZ_H, SZ_HU: return 2;
            SZ_W, SZ_WU: return 4;
            SZ_D, SZ_DU: return 8;
            default:     return 16;
        endcase
    endfunction

    function automatic addr_t aligned(addr_t a, size_e size);
        return a & ~addr_t'(size_bytes(size) - 1);
    endfunction

    // field shifted down, then sign or zero extended by size
    function automatic line_t model_load(line_t line, logic [3:0] off, size_e size);
        line_t mask;
        line_t v;
        int    nb;
        nb = size_bytes(size);
        if (nb == 16) begin
            return line;
        end
        mask = (128'd1 << (nb * 8)) - 1;
        v = (line >> (off * 8)) & mask;
        if ((size inside {SZ_B, SZ_H, SZ_W, SZ_D}) && v[nb * 8 - 1]) begin
            v = v | ~mask;
        end
        return v;
    endfunction

    function automatic logic [63:0] model_amo(cmd_e cmd, size_e size, logic [63:0] m,
                                              logic [63:0] c);
        logic signed [63:0] sm;
        logic signed [63:0] sc;
        if (size == SZ_W) begin
            m = {{32{m[31]}}, m[31:0]};  // word amos act on sign-extended values
            c = {{32{c[31]}}, c[31:0]};
        end
        sm = m;
        sc = c;
        case (cmd)
            CMD_AMOADD:  return m + c;
            CMD_AMOXOR:  return m ^ c;
            CMD_AMOOR:   return m | c;
            CMD_AMOAND:  return m & c;
            CMD_AMOMIN:  return (sm <= sc) ? m : c;
            CMD_AMOMAX:  return (sm >= sc) ? m : c;
            CMD_AMOMINU: return (m <= c) ? m : c;
            CMD_AMOMAXU: return (m >= c) ? m : c;
            default:     return c;  // store, swap, sc
        endcase
    endfunction

    function automatic line_t model_write(line_t old, dc_req_t req);
        logic [3:0]  off;
        logic [63:0] nv;
        line_t       mask;
        off = req.addr[3:0];
        if (req.size == SZ_LINE) begin
            return req.wdata;
        end
        nv = model_amo(req.cmd, req.size, 64'(model_load(old, off, req.size)), req.wdata[63:0]);
        mask = ((128'd1 << (size_bytes(req.size) * 8)) - 1) << (off * 8);
        return (old & ~mask) | ((line_t'(nv) << (off * 8)) & mask);
    endfunction

    // expected response, memory updated as at acceptance
    task automatic model_access(input dc_req_t req, output line_t resp);
        int idx;
        bit ok;
        idx = (req.addr >> 4) % MEM_LINES;
        resp = model_load(ref_mem[idx], req.addr[3:0], req.size);
        case (req.cmd)
            CMD_LOAD: ;
            CMD_LR: begin
                resv = 1'b1;
                resv_addr = req.addr;
            end
            CMD_SC: begin
                ok = resv && (resv_addr == req.addr);
                resv = 1'b0;
                resp = ok ? line_t'(0) : line_t'(1);
                if (ok) begin
                    ref_mem[idx] = model_write(ref_mem[idx], req);
                end
            end
            default: ref_mem[idx] = model_write(ref_mem[idx], req);
        endcase
    endtask

    task automatic fail_stop(string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_dc_resp(dc_resp_t got, dc_resp_t exp, bit data_known);
        if (got.tag !== exp.tag) begin
            fail_stop($sformatf("** Error at %0t: dc_resp_o.tag got %h expected %h",
                                $time, got.tag, exp.tag));
        end
        if (data_known && (got.data !== exp.data)) begin
            fail_stop($sformatf("** Error at %0t: dc_resp_o.data got %h expected %h",
                                $time, got.data, exp.data));
        end
    endtask

    task automatic check_ic_beat(ic_beat_t got, ic_beat_t exp);
        if (got !== exp) begin
            fail_stop($sformatf(
                "** Error at %0t: ic_beat_o got seq %0d line %h expected seq %0d line %h",
                $time, got.seq, got.line, exp.seq, exp.line));
        end
    endtask

    task automatic check_latency(int got, int exp, string name);
        if (got != exp) begin
            fail_stop($sformatf("** Error at %0t: %s got %0d expected %0d",
                                $time, name, got, exp));
        end
    endtask

    // one data request, called right after a rising edge
    task automatic dc_access(addr_t addr, cmd_e cmd, size_e size, line_t wdata, bit known);
        dc_req_t  req;
        dc_resp_t exp;
        int       n;
        req.addr  = addr;
        req.cmd   = cmd;
        req.size  = size;
        req.tag   = tag_t'(xorshift());
        req.wdata = wdata;
        exp.tag   = req.tag;
        model_access(req, exp.data);
        dc_req_i   <= req;
        dc_valid_i <= 1'b1;
        do @(posedge clk_i); while (!dc_ready_o);  // acceptance edge
        dc_valid_i <= 1'b0;
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
        end while (!dc_valid_o);
        check_latency(n, DATA_DELAY, "dc_valid_o delay");
        check_dc_resp(dc_resp_o, exp, known);
    endtask

    // store or amo on lines 8 to 15, read back at the same size
    task automatic amo_then_load();
        size_e sz;
        addr_t a;
        line_t wd;
        sz = (xorshift() & 1) ? SZ_D : SZ_W;
        a = aligned(xorshift(), sz);
        a[7] = 1'b1;
        wd = {xorshift(), xorshift(), xorshift(), xorshift()};
        dc_access(a, wr_cmds[xorshift() % 10], sz, wd, 1'b1);
        dc_access(a, CMD_LOAD, sz, '0, 1'b1);
    endtask

    task automatic refill(ic_addr_t grp);
        ic_beat_t exp;
        int       n;
        ic_addr_i  <= grp;
        ic_valid_i <= 1'b1;
        do @(posedge clk_i); while (!ic_ready_o);
        ic_valid_i <= 1'b0;
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
        end while (!ic_valid_o);
        check_latency(n, INST_DELAY, "first refill beat delay");
        for (int k = 0; k < 4; k++) begin
            if (k > 0) begin
                @(posedge clk_i);
                if (!ic_valid_o) begin
                    fail_stop($sformatf("refill burst stopped before beat %0d", k));
                end
            end
            exp = '{line: ref_mem[(int'(grp) * 4 + k) % MEM_LINES], seq: seq_t'(k)};
            check_ic_beat(ic_beat_o, exp);
        end
    endtask

    initial begin
        addr_t    a;
        size_e    sz;
        ic_addr_t g;
        rng_q      = 32'd65;
        resv       = 1'b0;
        resv_addr  = '0;
        rstn_i     = 1'b0;
        ic_addr_i  = '0;
        ic_valid_i = 1'b0;
        dc_req_i   = '0;
        dc_valid_i = 1'b0;
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(posedge clk_i);

        // fill every line; the old contents are unknown so only tags count
        for (int i = 0; i < MEM_LINES; i++) begin
            a = aligned(xorshift(), SZ_LINE);
            a[7:4] = 4'(i);
            dc_access(a, CMD_STORE, SZ_LINE, {xorshift(), xorshift(), xorshift(), xorshift()},
                      1'b0);
        end
        for (int i = 0; i < MEM_LINES; i++) begin
            dc_access(addr_t'(i * 16), CMD_LOAD, SZ_LINE, '0, 1'b1);
        end

        repeat (150) begin
            sz = size_e'(xorshift() % 9);
            dc_access(aligned(xorshift(), sz), CMD_LOAD, sz, '0, 1'b1);
        end

        repeat (150) amo_then_load();

        // lr/sc pairs on line 9
        dc_access(32'h90, CMD_SC, SZ_D, {4{xorshift()}}, 1'b1);  // nothing reserved
        dc_access(32'h90, CMD_LOAD, SZ_D, '0, 1'b1);
        dc_access(32'h90, CMD_LR, SZ_D, '0, 1'b1);
        dc_access(32'h90, CMD_SC, SZ_D, {4{xorshift()}}, 1'b1);
        dc_access(32'h90, CMD_LOAD, SZ_D, '0, 1'b1);
        dc_access(32'h90, CMD_LR, SZ_W, '0, 1'b1);
        dc_access(32'h98, CMD_SC, SZ_W, {4{xorshift()}}, 1'b1);  // other address
        dc_access(32'h98, CMD_LOAD, SZ_D, '0, 1'b1);
        dc_access(32'h90, CMD_LOAD, SZ_D, '0, 1'b1);

        // refills on lines 0 to 7 while the data side works on 8 to 15
        fork
            repeat (20) begin
                g = ic_addr_t'(xorshift());
                g[1] = 1'b0;
                refill(g);
            end
            repeat (30) amo_then_load();
        join
        @(posedge clk_i);

        if (DUT.u_mem_assert.fail_cnt == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
l2_geom_pkg.sv
l2_dc_pkg.sv
l2_line_store.sv
l2_amo_alu.sv
l2_icache_port.sv
l2_dcache_port.sv
l2_mem_top.sv
l2_mem_assert.sv
tb_l2_mem.sv
